/* design/video_pkg.sv */
`default_nettype none

package video_pkg;

  // one camera byte, also one luma pixel after reconstruction
  typedef logic [7:0] pixel_t;

  // column of a kept pixel, wide enough for 640
  typedef logic [9:0] hcount_t;

  // row inside the frame, wide enough for 360
  typedef logic [8:0] vcount_t;

  // luma pixels per line and lines per frame
  localparam int FRAME_W = 640;
  localparam int FRAME_H = 360;

  // flops per synchronizer chain
  localparam int SYNC_STAGES = 2;

  // camera sends Y and chroma bytes alternately, luma first on each line
  typedef enum logic {
    LUMA_BYTE,
    CHROMA_BYTE
  } luma_phase_t;

endpackage

`default_nettype wire

/* design/stream_pkg.sv */
`default_nettype none

package stream_pkg;

  // sixteen luma pixels, pixel 0 in the lowest byte
  typedef logic [127:0] chunk_t;

  localparam int PIXELS_PER_CHUNK = 16;

  // slot of a pixel inside its chunk
  typedef logic [3:0] chunk_idx_t;

  // chunk slots held while the receiver has no credits
  localparam int QUEUE_DEPTH = 4;

  // matches the receiver buffer
  localparam int INIT_CREDITS = 4;

  // counts 0 to INIT_CREDITS
  typedef logic [2:0] credit_t;

  // wraps naturally over the 4 queue slots
  typedef logic [1:0] queue_ptr_t;

  // 0 to QUEUE_DEPTH, needs one bit more than the pointer
  typedef logic [2:0] queue_count_t;

endpackage

`default_nettype wire

/* design/camera_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module camera_sync (
  input  wire                 clk_camera,
  input  wire                 recent_reset,
  input  wire video_pkg::pixel_t camera_d_i,
  input  wire                 cam_pclk_i,
  input  wire                 cam_hsync_i,
  input  wire                 cam_vsync_i,
  output video_pkg::pixel_t   data_o,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                pclk_rise_o
);
  import video_pkg::*;

  // data chain, stage 0 is closest to the pins
  pixel_t                 data_sync [SYNC_STAGES];
  logic [SYNC_STAGES-1:0] hsync_sync;
  logic [SYNC_STAGES-1:0] vsync_sync;
  logic [SYNC_STAGES-1:0] pclk_sync;
  // synchronized pclk one cycle back, for edge detection
  logic                   pclk_prev;

  // pins are wired MSB first, flip on entry
  always_ff @(posedge clk_camera) begin
    data_sync[0] <= {<<{camera_d_i}};
    for (int i = 1; i < SYNC_STAGES; i++) begin
      data_sync[i] <= data_sync[i-1];
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      hsync_sync  <= '0;
      vsync_sync  <= '0;
      pclk_sync   <= '0;
      pclk_prev   <= 1'b0;
      pclk_rise_o <= 1'b0;
    end else begin
      hsync_sync  <= {hsync_sync[SYNC_STAGES-2:0], cam_hsync_i};
      vsync_sync  <= {vsync_sync[SYNC_STAGES-2:0], cam_vsync_i};
      pclk_sync   <= {pclk_sync[SYNC_STAGES-2:0], cam_pclk_i};
      pclk_prev   <= pclk_sync[SYNC_STAGES-1];
      // one pulse per camera pixel clock, a cycle after it is seen high
      pclk_rise_o <= pclk_sync[SYNC_STAGES-1] && !pclk_prev;
    end
  end

  assign data_o  = data_sync[SYNC_STAGES-1];
  assign hsync_o = hsync_sync[SYNC_STAGES-1];
  assign vsync_o = vsync_sync[SYNC_STAGES-1];

endmodule

`default_nettype wire

/* design/luminance_reconstruct.sv */
`timescale 1ns/1ps
`default_nettype none

module luminance_reconstruct #(
  parameter int FRAME_W = video_pkg::FRAME_W,
  parameter int FRAME_H = video_pkg::FRAME_H
) (
  input  wire                    clk_camera,
  input  wire                    recent_reset,
  input  wire video_pkg::pixel_t data_i,
  input  wire                    hsync_i,
  input  wire                    vsync_i,
  input  wire                    pclk_rise_i,
  output logic                   pixel_valid_o,
  output video_pkg::pixel_t      pixel_o,
  output logic                   pixel_last_o
);
  import video_pkg::*;

  luma_phase_t phase;
  hcount_t     hcount;
  vcount_t     vcount;
  logic        hsync_prev;
  logic        hsync_fall;
  // a byte is taken only on a pclk edge inside the active line
  logic        byte_sample;
  logic        keep_byte;
  logic        at_frame_end;

  assign hsync_fall   = hsync_prev && !hsync_i;
  assign byte_sample  = pclk_rise_i && hsync_i;
  assign keep_byte    = byte_sample && (phase == LUMA_BYTE);
  assign at_frame_end = (hcount == hcount_t'(FRAME_W - 1)) &&
                        (vcount == vcount_t'(FRAME_H - 1));

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      phase         <= LUMA_BYTE;
      hcount        <= '0;
      vcount        <= '0;
      hsync_prev    <= 1'b0;
      pixel_valid_o <= 1'b0;
      pixel_last_o  <= 1'b0;
    end else begin
      hsync_prev    <= hsync_i;
      pixel_valid_o <= keep_byte && !vsync_i;
      pixel_last_o  <= keep_byte && !vsync_i && at_frame_end;
      if (vsync_i) begin
        // frame blanking, start over at the top left
        phase  <= LUMA_BYTE;
        hcount <= '0;
        vcount <= '0;
      end else if (hsync_fall) begin
        // end of line, next one starts on a luma byte
        phase  <= LUMA_BYTE;
        hcount <= '0;
        vcount <= vcount + 1'b1;
      end else if (byte_sample) begin
        case (phase)
          LUMA_BYTE: begin
            phase  <= CHROMA_BYTE;
            hcount <= hcount + 1'b1;
          end
          default: phase <= LUMA_BYTE;
        endcase
      end
    end
  end

  // pixel value only matters while pixel_valid_o is high
  always_ff @(posedge clk_camera) begin
    if (keep_byte) begin
      pixel_o <= data_i;
    end
  end

endmodule

`default_nettype wire

/* design/chunk_stacker.sv */
`timescale 1ns/1ps
`default_nettype none

module chunk_stacker (
  input  wire                    clk_camera,
  input  wire                    recent_reset,
  input  wire                    pixel_valid_i,
  input  wire video_pkg::pixel_t pixel_i,
  input  wire                    pixel_last_i,
  output logic                   stack_valid_o,
  output stream_pkg::chunk_t     stack_data_o,
  output logic                   stack_last_o
);
  import video_pkg::*;
  import stream_pkg::*;

  // next slot to fill, wraps after the sixteenth pixel
  chunk_idx_t slot;
  logic       slot_full;

  assign slot_full = (slot == chunk_idx_t'(PIXELS_PER_CHUNK - 1));

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      slot          <= '0;
      stack_valid_o <= 1'b0;
      stack_last_o  <= 1'b0;
    end else begin
      stack_valid_o <= pixel_valid_i && slot_full;
      // frames are whole chunks, so only the closing pixel can carry last
      stack_last_o  <= pixel_valid_i && slot_full && pixel_last_i;
      if (pixel_valid_i) begin
        slot <= slot + 1'b1;
      end
    end
  end

  // slot 0 lands in the lowest byte
  always_ff @(posedge clk_camera) begin
    if (pixel_valid_i) begin
      stack_data_o[slot*$bits(pixel_t) +: $bits(pixel_t)] <= pixel_i;
    end
  end

endmodule

`default_nettype wire

/* design/credit_chunk_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_chunk_queue (
  input  wire                     clk_camera,
  input  wire                     recent_reset,
  input  wire                     stack_valid_i,
  input  wire stream_pkg::chunk_t stack_data_i,
  input  wire                     stack_last_i,
  input  wire                     credit_i,
  output logic                    chunk_valid_o,
  output stream_pkg::chunk_t      chunk_data_o,
  output logic                    chunk_last_o,
  output logic                    overflow_o
);
  import stream_pkg::*;

  chunk_t       chunk_mem [QUEUE_DEPTH];
  logic         last_mem  [QUEUE_DEPTH];
  queue_ptr_t   rd_ptr;
  queue_ptr_t   wr_ptr;
  queue_count_t count;
  credit_t      credits;
  logic         empty;
  logic         full;
  logic         send;
  // empty queue, incoming chunk goes straight to the output
  logic         bypass;
  logic         pop;
  logic         push;
  logic         drop;

  assign empty  = (count == '0);
  assign full   = (count == queue_count_t'(QUEUE_DEPTH));
  assign send   = (credits != '0) && (!empty || stack_valid_i);
  assign bypass = send && empty;
  assign pop    = send && !empty;
  // a full queue still takes the chunk if the head leaves this cycle
  assign push   = stack_valid_i && !bypass && (!full || pop);
  assign drop   = stack_valid_i && !bypass && full && !pop;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      rd_ptr        <= '0;
      wr_ptr        <= '0;
      count         <= '0;
      credits       <= credit_t'(INIT_CREDITS);
      chunk_valid_o <= 1'b0;
      chunk_last_o  <= 1'b0;
      overflow_o    <= 1'b0;
    end else begin
      chunk_valid_o <= send;
      chunk_last_o  <= send && (bypass ? stack_last_i : last_mem[rd_ptr]);
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      count <= count + queue_count_t'(push) - queue_count_t'(pop);
      // send and returned credit together cancel out
      credits <= credits - credit_t'(send) + credit_t'(credit_i);
      // sticky until reset
      if (drop) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (push) begin
      chunk_mem[wr_ptr] <= stack_data_i;
      last_mem[wr_ptr]  <= stack_last_i;
    end
  end

  // head or bypass data, valid only with chunk_valid_o
  always_ff @(posedge clk_camera) begin
    if (send) begin
      chunk_data_o <= bypass ? stack_data_i : chunk_mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

/* design/camera_capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module camera_capture_top #(
  parameter int FRAME_W = video_pkg::FRAME_W,
  parameter int FRAME_H = video_pkg::FRAME_H
) (
  input  wire                    clk_camera,
  input  wire                    recent_reset,
  input  wire video_pkg::pixel_t camera_d_i,
  input  wire                    cam_pclk_i,
  input  wire                    cam_hsync_i,
  input  wire                    cam_vsync_i,
  input  wire                    credit_i,
  output logic                   chunk_valid_o,
  output stream_pkg::chunk_t     chunk_data_o,
  output logic                   chunk_last_o,
  output logic                   overflow_o
);
  import video_pkg::*;
  import stream_pkg::*;

  // synchronized camera bus, bit order restored
  logic   pclk_rise;
  logic   hsync;
  logic   vsync;
  pixel_t data;

  // luma pixel stream
  logic   pixel_valid;
  pixel_t pixel;
  logic   pixel_last;

  // 128-bit chunks toward the queue
  logic   stack_valid;
  chunk_t stack_data;
  logic   stack_last;

  camera_sync u_camera_sync (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .camera_d_i   (camera_d_i),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .data_o       (data),
    .hsync_o      (hsync),
    .vsync_o      (vsync),
    .pclk_rise_o  (pclk_rise)
  );

  luminance_reconstruct #(
    .FRAME_W (FRAME_W),
    .FRAME_H (FRAME_H)
  ) u_luminance_reconstruct (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .data_i        (data),
    .hsync_i       (hsync),
    .vsync_i       (vsync),
    .pclk_rise_i   (pclk_rise),
    .pixel_valid_o (pixel_valid),
    .pixel_o       (pixel),
    .pixel_last_o  (pixel_last)
  );

  chunk_stacker u_chunk_stacker (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pixel_valid_i (pixel_valid),
    .pixel_i       (pixel),
    .pixel_last_i  (pixel_last),
    .stack_valid_o (stack_valid),
    .stack_data_o  (stack_data),
    .stack_last_o  (stack_last)
  );

  credit_chunk_queue u_credit_chunk_queue (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .stack_valid_i (stack_valid),
    .stack_data_i  (stack_data),
    .stack_last_i  (stack_last),
    .credit_i      (credit_i),
    .chunk_valid_o (chunk_valid_o),
    .chunk_data_o  (chunk_data_o),
    .chunk_last_o  (chunk_last_o),
    .overflow_o    (overflow_o)
  );

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int HALF_PERIOD_NS = 20,
  parameter int RESET_CYCLES   = 16
) (
  output logic clk_camera_o,
  output logic recent_reset_o
);

  // 40 ns camera clock
  initial begin
    clk_camera_o = 1'b0;
    forever #HALF_PERIOD_NS clk_camera_o = ~clk_camera_o;
  end

  // reset released just after the last reset edge
  initial begin
    recent_reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_camera_o);
    #1 recent_reset_o = 1'b0;
  end

endmodule

`default_nettype wire

/* tb/capture_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_checker #(
  parameter int FRAME_W = video_pkg::FRAME_W,
  parameter int FRAME_H = video_pkg::FRAME_H
) (
  input wire                     clk_camera,
  input wire                     recent_reset,
  input wire                     chunk_valid_i,
  input wire stream_pkg::chunk_t chunk_data_i,
  input wire                     chunk_last_i,
  input wire                     overflow_i
);
  import video_pkg::*;
  import stream_pkg::*;

  localparam int CHUNKS_PER_FRAME = FRAME_W * FRAME_H / PIXELS_PER_CHUNK;

  // expected chunks in arrival order
  chunk_t exp_data [$];
  logic   exp_last [$];
  string  test_name   = "idle";
  logic   started     = 1'b0;
  logic   ovf_seen    = 1'b0;
  int     error_count = 0;
  int     chunk_count = 0;
  // chunks seen in the current test
  int     row_seen    = 0;

  // luma pixel n of a frame is base + n, pixel 0 in the lowest byte
  task automatic start_test(input string name, input pixel_t base, input int frames);
    chunk_t chunk;
    int     index;
    test_name = name;
    started   = 1'b1;
    row_seen  = 0;
    for (int f = 0; f < frames; f++) begin
      for (int c = 0; c < CHUNKS_PER_FRAME; c++) begin
        for (int k = 0; k < PIXELS_PER_CHUNK; k++) begin
          index = c * PIXELS_PER_CHUNK + k;
          chunk[k*$bits(pixel_t) +: $bits(pixel_t)] = pixel_t'(int'(base) + index);
        end
        exp_data.push_back(chunk);
        exp_last.push_back(c == CHUNKS_PER_FRAME - 1);
      end
    end
  endtask

  // with credits held, only the initial credits can be spent
  task automatic check_held();
    if (row_seen != INIT_CREDITS) begin
      error_count++;
      $display("FAIL %s: chunks before credit return expected %0d actual %0d",
               test_name, INIT_CREDITS, row_seen);
    end
  endtask

  task automatic end_test(input logic want_overflow);
    if (overflow_i !== want_overflow) begin
      error_count++;
      $display("FAIL %s: overflow expected %b actual %b", test_name, want_overflow, overflow_i);
    end
    exp_data.delete();
    exp_last.delete();
  endtask

  task automatic compare_chunk();
    chunk_t want_data;
    logic   want_last;
    chunk_count++;
    row_seen++;
    if (exp_data.size() == 0) begin
      error_count++;
      $display("test %s: a chunk arrived when none was expected", test_name);
    end else begin
      want_data = exp_data.pop_front();
      want_last = exp_last.pop_front();
      if (chunk_data_i !== want_data) begin
        error_count++;
        $display("FAIL %s: chunk %0d data expected %h actual %h",
                 test_name, row_seen - 1, want_data, chunk_data_i);
      end
      if (chunk_last_i !== want_last) begin
        error_count++;
        $display("FAIL %s: chunk %0d last expected %b actual %b",
                 test_name, row_seen - 1, want_last, chunk_last_i);
      end
    end
  endtask

  // outputs settle after the rising edge, sample on the falling one
  always @(negedge clk_camera) begin
    if (!recent_reset) begin
      if (!started && (chunk_valid_i || chunk_last_i || overflow_i)) begin
        error_count++;
        $display("outputs went active after reset before any pixel was sent");
      end
      // overflow is sticky until reset
      if (ovf_seen && !overflow_i) begin
        error_count++;
        $display("test %s: overflow flag dropped before reset", test_name);
      end
      ovf_seen = ovf_seen || overflow_i;
      if (chunk_valid_i) begin
        compare_chunk();
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_camera_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_camera_capture;
  import video_pkg::*;
  import stream_pkg::*;

  localparam int TEST_W      = 32;
  localparam int TEST_H      = 4;
  localparam int PCLK_DIV    = 4;
  localparam int VSYNC_PCLKS = 4;
  localparam int GAP_PCLKS   = 8;
  localparam int NUM_TESTS   = 4;
  localparam int CHUNKS_PER_FRAME = TEST_W * TEST_H / PIXELS_PER_CHUNK;
  // pins move after the edge, credits a little earlier than that
  localparam int DRIVE_DELAY  = 2;
  localparam int CREDIT_DELAY = 1;
  localparam bit CREDIT_NOW  = 1'b0;
  localparam bit CREDIT_HOLD = 1'b1;

  // stimulus table, one row per test
  string  test_name   [NUM_TESTS] = '{"immediate_one", "immediate_two", "held_one",
                                      "held_overflow"};
  pixel_t luma_base   [NUM_TESTS] = '{8'h10, 8'h25, 8'h03, 8'h40};
  bit     credit_mode [NUM_TESTS] = '{CREDIT_NOW, CREDIT_NOW, CREDIT_HOLD, CREDIT_HOLD};
  int     num_frames  [NUM_TESTS] = '{1, 2, 1, 2};
  bit     exp_overflow[NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1};

  logic   clk_camera;
  logic   recent_reset;
  pixel_t camera_d;
  logic   cam_pclk;
  logic   cam_hsync;
  logic   cam_vsync;
  logic   credit;
  logic   chunk_valid;
  chunk_t chunk_data;
  logic   chunk_last;
  logic   overflow;

  int     seed = 32'h31afa497;
  logic   hold_credits = 1'b0;
  // chunks received but not yet paid back
  int     outstanding = 0;
  int     cycle_count = 0;
  int     timeout_limit = 0;
  int     current_test = 0;

  clock_gen u_clock_gen (
    .clk_camera_o   (clk_camera),
    .recent_reset_o (recent_reset)
  );

  camera_capture_top #(
    .FRAME_W (TEST_W),
    .FRAME_H (TEST_H)
  ) dut (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .camera_d_i    (camera_d),
    .cam_pclk_i    (cam_pclk),
    .cam_hsync_i   (cam_hsync),
    .cam_vsync_i   (cam_vsync),
    .credit_i      (credit),
    .chunk_valid_o (chunk_valid),
    .chunk_data_o  (chunk_data),
    .chunk_last_o  (chunk_last),
    .overflow_o    (overflow)
  );

  capture_checker #(
    .FRAME_W (TEST_W),
    .FRAME_H (TEST_H)
  ) u_checker (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .chunk_valid_i (chunk_valid),
    .chunk_data_i  (chunk_data),
    .chunk_last_i  (chunk_last),
    .overflow_i    (overflow)
  );

  // camera pins carry the data MSB first
  function automatic pixel_t reverse_bits(input pixel_t value);
    pixel_t flipped;
    for (int i = 0; i < $bits(pixel_t); i++) begin
      flipped[i] = value[$bits(pixel_t)-1-i];
    end
    return flipped;
  endfunction

  // one pclk period, low half first so data is stable at the rise
  task automatic drive_byte(input pixel_t value);
    camera_d = reverse_bits(value);
    cam_pclk = 1'b0;
    repeat (PCLK_DIV / 2) @(posedge clk_camera);
    #DRIVE_DELAY;
    cam_pclk = 1'b1;
    repeat (PCLK_DIV / 2) @(posedge clk_camera);
    #DRIVE_DELAY;
  endtask

  task automatic drive_frame(input pixel_t base);
    pixel_t chroma;
    cam_vsync = 1'b1;
    repeat (VSYNC_PCLKS) drive_byte(8'h00);
    cam_vsync = 1'b0;
    for (int row = 0; row < TEST_H; row++) begin
      cam_hsync = 1'b1;
      for (int col = 0; col < TEST_W; col++) begin
        drive_byte(pixel_t'(int'(base) + row * TEST_W + col));
        // chroma kept above every luma value of the table
        chroma = pixel_t'($random(seed)) | 8'hC0;
        drive_byte(chroma);
      end
      cam_hsync = 1'b0;
      repeat (GAP_PCLKS) drive_byte(8'h00);
    end
  endtask

  task automatic print_counts();
    $display("checked %0d chunks, %0d errors", u_checker.chunk_count, u_checker.error_count);
  endtask

  // receiver model, pays back one credit per cycle unless holding
  always @(posedge clk_camera) begin
    #CREDIT_DELAY;
    if (recent_reset) begin
      credit      = 1'b0;
      outstanding = 0;
    end else begin
      if (chunk_valid) begin
        outstanding = outstanding + 1;
      end
      if (!hold_credits && outstanding > 0) begin
        credit      = 1'b1;
        outstanding = outstanding - 1;
      end else begin
        credit = 1'b0;
      end
    end
  end

  always @(posedge clk_camera) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      $display("timeout after %0d cycles in test %s, chunks stopped arriving",
               cycle_count, test_name[current_test]);
      print_counts();
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    int total_frames;
    int target;
    camera_d  = '0;
    cam_pclk  = 1'b0;
    cam_hsync = 1'b0;
    cam_vsync = 1'b0;
    credit    = 1'b0;
    total_frames = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total_frames += num_frames[t];
    end
    // every byte slot lasts PCLK_DIV cycles, plus reset and drain margin
    timeout_limit = total_frames * PCLK_DIV *
                    (VSYNC_PCLKS + TEST_H * (2 * TEST_W + GAP_PCLKS)) + 2000;
    while (recent_reset) @(posedge clk_camera);
    #DRIVE_DELAY;
    // quiet bus, outputs must stay low
    repeat (20) @(posedge clk_camera);
    #DRIVE_DELAY;
    for (int t = 0; t < NUM_TESTS; t++) begin
      current_test = t;
      u_checker.start_test(test_name[t], luma_base[t], num_frames[t]);
      hold_credits = credit_mode[t];
      for (int f = 0; f < num_frames[t]; f++) begin
        drive_frame(luma_base[t]);
      end
      if (credit_mode[t] == CREDIT_HOLD) begin
        u_checker.check_held();
        hold_credits = 1'b0;
      end
      // an overflowing test only gets the sent and queued chunks back
      target = exp_overflow[t] ? INIT_CREDITS + QUEUE_DEPTH
                               : num_frames[t] * CHUNKS_PER_FRAME;
      while (u_checker.row_seen < target || outstanding != 0) begin
        @(posedge clk_camera);
        #DRIVE_DELAY;
      end
      u_checker.end_test(exp_overflow[t]);
    end
    print_counts();
    if (u_checker.error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
design/video_pkg.sv
design/stream_pkg.sv
design/camera_sync.sv
design/luminance_reconstruct.sv
design/chunk_stacker.sv
design/credit_chunk_queue.sv
design/camera_capture_top.sv
tb/clock_gen.sv
tb/capture_checker.sv
tb/tb_camera_capture.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing -j 0
TOP       := tb_camera_capture
FILELIST  := project.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
